// File: Makefile
# Verilator build and run for the RVC decompressor testbench

VERILATOR ?= verilator
TOP       ?= tb_rvc_decompressor
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+.
rvc_pkg.sv
rvc_field_extract.sv
rvc_q0_expand.sv
rvc_q1_expand.sv
rvc_q2_expand.sv
rvc_expand.sv
rvc_fetch_align.sv
rvc_decompressor.sv
tb_rvc_decompressor.sv

// File: rvc_decompressor.sv
// RV32C decompressor top level
// Fetch alignment feeding the compressed expander
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_decompressor (
    input  rvc_pkg::fetch_in_t   fetch,
    output rvc_pkg::decomp_out_t result
);

    // Active parcel out of alignment, expansion back in
    rvc_pkg::rvc_half_t current_half;
    rvc_pkg::rv_instr_t expanded;

    rvc_fetch_align u_align (
        .fetch        (fetch),
        .expanded     (expanded),
        .current_half (current_half),
        .result       (result)
    );

    rvc_expand u_expand (
        .current_half (current_half),
        .expanded     (expanded)
    );

endmodule

// File: rvc_expand.sv
// Compressed parcel expander
// Field extraction and per-quadrant selection
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_expand (
    input  rvc_pkg::rvc_half_t current_half,
    output rvc_pkg::rv_instr_t expanded
);

    rvc_pkg::rvc_fields_t  fields;
    rvc_pkg::rvc_quadrant_e quadrant;
    rvc_pkg::rv_instr_t    q0_instr;
    rvc_pkg::rv_instr_t    q1_instr;
    rvc_pkg::rv_instr_t    q2_instr;

    rvc_field_extract u_fields (.half(current_half), .fields(fields));

    // All three expanders run in parallel
    rvc_q0_expand u_q0 (.fields(fields), .instr(q0_instr));
    rvc_q1_expand u_q1 (.fields(fields), .instr(q1_instr));
    rvc_q2_expand u_q2 (.fields(fields), .instr(q2_instr));

    assign quadrant = rvc_pkg::rvc_quadrant_e'(current_half[1:0]);

    always_comb begin
        case (quadrant)
            rvc_pkg::C0: expanded = q0_instr;
            rvc_pkg::C1: expanded = q1_instr;
            rvc_pkg::C2: expanded = q2_instr;
            // Full-width parcels are not handled here
            default:     expanded = `RVC_NOP_WORD;
        endcase
    end

endmodule

// File: rvc_fetch_align.sv
// Fetch alignment
// Half selection, word-boundary spanning and output selection
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_fetch_align (
    input  rvc_pkg::fetch_in_t   fetch,
    input  rvc_pkg::rv_instr_t   expanded,
    output rvc_pkg::rvc_half_t   current_half,
    output rvc_pkg::decomp_out_t result
);

    logic               half_compressed;
    rvc_pkg::rv_instr_t spanning_word;

    // pc_bit1 picks the upper parcel
    assign current_half = fetch.pc_bit1 ? fetch.fetched_word[`RVC_XLEN-1:`RVC_HALF_W]
                                        : fetch.fetched_word[`RVC_HALF_W-1:0];

    // Low bits 11 mark a full-width instruction
    assign half_compressed = (current_half[1:0] != 2'b11);

    // Saved upper half is the low part, new low half completes it
    assign spanning_word = {fetch.fetched_word[`RVC_HALF_W-1:0], fetch.saved_half};

    // Upper-half start of a 32-bit instruction needs one more parcel
    assign result.need_next_half = fetch.pc_bit1 && !half_compressed && !fetch.have_saved;
    assign result.is_compressed  = half_compressed && !fetch.have_saved;

    // Priority order: spanning, expanded, waiting, pass-through
    always_comb begin
        if (fetch.have_saved) begin
            result.instruction = spanning_word;
        end else if (half_compressed) begin
            result.instruction = expanded;
        end else if (fetch.pc_bit1) begin
            result.instruction = `RVC_NOP_WORD;
        end else begin
            result.instruction = fetch.fetched_word;
        end
    end

endmodule

// File: rvc_field_extract.sv
// Field slicer for one compressed parcel
// Register fields, prime registers and unscrambled immediates
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_field_extract (
    input  rvc_pkg::rvc_half_t   half,
    output rvc_pkg::rvc_fields_t fields
);

    // Raw immediate vectors before sign extension
    logic [5:0]  imm6;
    logic [11:0] j_off;
    logic [8:0]  b_off;
    logic [9:0]  addi16sp_imm;

    assign imm6 = {half[12], half[6:2]};

    // CJ offset, bit 0 always zero
    assign j_off = {half[12], half[8], half[10:9], half[6], half[7],
                    half[2], half[11], half[5:3], 1'b0};

    // CB offset, bit 0 always zero
    assign b_off = {half[12], half[6:5], half[2], half[11:10], half[4:3], 1'b0};

    // Stack adjust in units of 16 bytes
    assign addi16sp_imm = {half[12], half[4:3], half[5], half[2], half[6], 4'b0000};

    // ========================================
    // Register and function fields
    // ========================================
    assign fields.funct3    = half[15:13];
    assign fields.rd_rs1    = half[11:7];
    assign fields.rs2       = half[6:2];
    assign fields.rd_prime  = {`RVC_PRIME_BASE, half[4:2]};
    assign fields.rs1_prime = {`RVC_PRIME_BASE, half[9:7]};
    assign fields.bit12     = half[12];
    // Selects the C1 arithmetic sub-op
    assign fields.funct2_hi = half[11:10];
    assign fields.funct2_lo = half[6:5];
    assign fields.shamt     = {half[12], half[6:2]};

    // ========================================
    // Immediates
    // ========================================
    assign fields.imm6_sext = {{6{imm6[5]}}, imm6};

    // Zero-extended, word aligned
    assign fields.addi4spn_imm = {half[10:7], half[12:11], half[5], half[6], 2'b00};
    assign fields.lw_sw_off    = {half[5], half[12:10], half[6], 2'b00};

    assign fields.j_off_sext    = {{9{j_off[11]}}, j_off};
    assign fields.b_off_sext    = {{4{b_off[8]}}, b_off};
    assign fields.addi16sp_sext = {{2{addi16sp_imm[9]}}, addi16sp_imm};

    // Upper bits 17:12 of the LUI value
    assign fields.lui_imm6 = {half[12], half[6:2]};

    // SP-relative word offsets
    assign fields.lwsp_off = {half[3:2], half[12], half[6:4], 2'b00};
    assign fields.swsp_off = {half[8:7], half[12:9], 2'b00};

endmodule

// File: rvc_pkg.sv
// Shared types for the RVC decompressor
// Quadrant and opcode enums, instruction words and port structs
`include "rvc_settings.svh"

package rvc_pkg;

    // ========================================
    // Enums
    // ========================================

    // Low two bits of a parcel
    typedef enum logic [1:0] {
        C0             = 2'b00,
        C1             = 2'b01,
        C2             = 2'b10,
        NOT_COMPRESSED = 2'b11
    } rvc_quadrant_e;

    // RV32I major opcodes produced by the expanders
    typedef enum logic [6:0] {
        OP_IMM = 7'b001_0011,
        LOAD   = 7'b000_0011,
        STORE  = 7'b010_0011,
        OP     = 7'b011_0011,
        LUI    = 7'b011_0111,
        JAL    = 7'b110_1111,
        JALR   = 7'b110_0111,
        BRANCH = 7'b110_0011,
        SYSTEM = 7'b111_0011
    } rv_opcode_e;

    // ========================================
    // Words and ports
    // ========================================

    typedef logic [`RVC_XLEN-1:0]   rv_instr_t;
    typedef logic [`RVC_HALF_W-1:0] rvc_half_t;

    // What the fetch stage hands over, 50 bits
    typedef struct packed {
        rv_instr_t fetched_word;
        logic      pc_bit1;
        rvc_half_t saved_half;
        logic      have_saved;
    } fetch_in_t;

    // What goes back to the pipeline, 34 bits
    typedef struct packed {
        rv_instr_t instruction;
        logic      is_compressed;
        logic      need_next_half;
    } decomp_out_t;

    // Decoded fields of one compressed parcel
    typedef struct packed {
        // Raw register and function fields
        logic [2:0]  funct3;
        logic [4:0]  rd_rs1;
        logic [4:0]  rs2;
        // rd' in CIW/CL, rs2' in CS/CA
        logic [4:0]  rd_prime;
        logic [4:0]  rs1_prime;
        logic        bit12;
        logic [1:0]  funct2_hi;
        logic [1:0]  funct2_lo;
        logic [5:0]  shamt;
        // CI immediate, sign-extended to 12 bits
        logic [11:0] imm6_sext;
        // Reordered immediates
        logic [9:0]  addi4spn_imm;
        logic [6:0]  lw_sw_off;
        logic [20:0] j_off_sext;
        logic [12:0] b_off_sext;
        logic [11:0] addi16sp_sext;
        logic [5:0]  lui_imm6;
        logic [7:0]  lwsp_off;
        logic [7:0]  swsp_off;
    } rvc_fields_t;

endpackage

// File: rvc_q0_expand.sv
// Quadrant 0 expander
// C.ADDI4SPN, C.LW and C.SW
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_q0_expand (
    input  rvc_pkg::rvc_fields_t fields,
    output rvc_pkg::rv_instr_t   instr
);

    always_comb begin
        // Reserved and FP slots fall through as NOP
        instr = `RVC_NOP_WORD;
        case (fields.funct3)
            // addi rd', sp, nzuimm
            3'b000: begin
                if (fields.addi4spn_imm != 10'd0) begin
                    instr = {2'b00, fields.addi4spn_imm, `RVC_REG_SP, 3'b000,
                             fields.rd_prime, rvc_pkg::OP_IMM};
                end
            end
            // lw rd', off(rs1')
            3'b010: begin
                instr = {5'b00000, fields.lw_sw_off, fields.rs1_prime, 3'b010,
                         fields.rd_prime, rvc_pkg::LOAD};
            end
            // sw rs2', off(rs1'), S-type splits the offset
            3'b110: begin
                instr = {5'b00000, fields.lw_sw_off[6:5], fields.rd_prime, fields.rs1_prime,
                         3'b010, fields.lw_sw_off[4:0], rvc_pkg::STORE};
            end
            default: instr = `RVC_NOP_WORD;
        endcase
    end

endmodule

// File: rvc_q1_expand.sv
// Quadrant 1 expander
// ADDI, JAL, LI, LUI/ADDI16SP, shift/logic group, J and branches
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_q1_expand (
    input  rvc_pkg::rvc_fields_t fields,
    output rvc_pkg::rv_instr_t   instr
);

    // Shared pieces of the jump and branch encodings
    logic [19:0] j_imm_field;
    logic [6:0]  b_imm_hi;
    logic [4:0]  b_imm_lo;
    // Zero shift is a HINT, bit 5 is reserved on RV32
    logic        shamt_bad;
    logic        rd_zero;

    // J-type order imm[20|10:1|11|19:12]
    assign j_imm_field = {fields.j_off_sext[20], fields.j_off_sext[10:1],
                          fields.j_off_sext[11], fields.j_off_sext[19:12]};
    // B-type order imm[12|10:5] and imm[4:1|11]
    assign b_imm_hi = {fields.b_off_sext[12], fields.b_off_sext[10:5]};
    assign b_imm_lo = {fields.b_off_sext[4:1], fields.b_off_sext[11]};

    assign shamt_bad = (fields.shamt == 6'd0) || fields.shamt[5];
    assign rd_zero   = (fields.rd_rs1 == `RVC_REG_ZERO);

    always_comb begin
        instr = `RVC_NOP_WORD;
        case (fields.funct3)
            // C.ADDI, rd zero is C.NOP
            3'b000: begin
                if (!rd_zero) begin
                    instr = {fields.imm6_sext, fields.rd_rs1, 3'b000,
                             fields.rd_rs1, rvc_pkg::OP_IMM};
                end
            end
            // C.JAL links through ra
            3'b001: instr = {j_imm_field, `RVC_REG_RA, rvc_pkg::JAL};
            // C.LI is addi rd, x0, imm
            3'b010: begin
                if (!rd_zero) begin
                    instr = {fields.imm6_sext, `RVC_REG_ZERO, 3'b000,
                             fields.rd_rs1, rvc_pkg::OP_IMM};
                end
            end
            // rd sp selects ADDI16SP, anything else LUI
            3'b011: begin
                if (fields.rd_rs1 == `RVC_REG_SP) begin
                    if (fields.addi16sp_sext != 12'd0) begin
                        instr = {fields.addi16sp_sext, `RVC_REG_SP, 3'b000,
                                 `RVC_REG_SP, rvc_pkg::OP_IMM};
                    end
                end else if (!rd_zero && fields.lui_imm6 != 6'd0) begin
                    instr = {{14{fields.lui_imm6[5]}}, fields.lui_imm6,
                             fields.rd_rs1, rvc_pkg::LUI};
                end
            end
            // ========================================
            // Arithmetic group on x8..x15
            // ========================================
            3'b100: begin
                case (fields.funct2_hi)
                    // SRLI
                    2'b00: begin
                        if (!shamt_bad) begin
                            instr = {7'b000_0000, fields.shamt[4:0], fields.rs1_prime, 3'b101,
                                     fields.rs1_prime, rvc_pkg::OP_IMM};
                        end
                    end
                    // SRAI sets funct7 bit 5
                    2'b01: begin
                        if (!shamt_bad) begin
                            instr = {7'b010_0000, fields.shamt[4:0], fields.rs1_prime, 3'b101,
                                     fields.rs1_prime, rvc_pkg::OP_IMM};
                        end
                    end
                    // ANDI
                    2'b10: begin
                        instr = {fields.imm6_sext, fields.rs1_prime, 3'b111,
                                 fields.rs1_prime, rvc_pkg::OP_IMM};
                    end
                    // SUB/XOR/OR/AND, bit 12 set belongs to RV64 only
                    default: begin
                        if (!fields.bit12) begin
                            case (fields.funct2_lo)
                                2'b00: instr = {7'b010_0000, fields.rd_prime, fields.rs1_prime,
                                                3'b000, fields.rs1_prime, rvc_pkg::OP};
                                2'b01: instr = {7'b000_0000, fields.rd_prime, fields.rs1_prime,
                                                3'b100, fields.rs1_prime, rvc_pkg::OP};
                                2'b10: instr = {7'b000_0000, fields.rd_prime, fields.rs1_prime,
                                                3'b110, fields.rs1_prime, rvc_pkg::OP};
                                default: instr = {7'b000_0000, fields.rd_prime, fields.rs1_prime,
                                                  3'b111, fields.rs1_prime, rvc_pkg::OP};
                            endcase
                        end
                    end
                endcase
            end
            // C.J discards the link
            3'b101: instr = {j_imm_field, `RVC_REG_ZERO, rvc_pkg::JAL};
            // BEQZ and BNEZ compare rs1' against x0
            3'b110: instr = {b_imm_hi, `RVC_REG_ZERO, fields.rs1_prime, 3'b000,
                             b_imm_lo, rvc_pkg::BRANCH};
            default: instr = {b_imm_hi, `RVC_REG_ZERO, fields.rs1_prime, 3'b001,
                              b_imm_lo, rvc_pkg::BRANCH};
        endcase
    end

endmodule

// File: rvc_q2_expand.sv
// Quadrant 2 expander
// SLLI, LWSP, JR/MV/EBREAK/JALR/ADD and SWSP
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_q2_expand (
    input  rvc_pkg::rvc_fields_t fields,
    output rvc_pkg::rv_instr_t   instr
);

    logic rd_zero;
    logic rs2_zero;
    logic shamt_bad;

    assign rd_zero   = (fields.rd_rs1 == `RVC_REG_ZERO);
    assign rs2_zero  = (fields.rs2 == `RVC_REG_ZERO);
    // Same RV32 shift rule as quadrant 1
    assign shamt_bad = (fields.shamt == 6'd0) || fields.shamt[5];

    always_comb begin
        // FLDSP/FLWSP/FSDSP/FSWSP slots stay NOP
        instr = `RVC_NOP_WORD;
        case (fields.funct3)
            // slli rd, rd, shamt
            3'b000: begin
                if (!rd_zero && !shamt_bad) begin
                    instr = {7'b000_0000, fields.shamt[4:0], fields.rd_rs1, 3'b001,
                             fields.rd_rs1, rvc_pkg::OP_IMM};
                end
            end
            // lw rd, off(sp)
            3'b010: begin
                if (!rd_zero) begin
                    instr = {4'b0000, fields.lwsp_off, `RVC_REG_SP, 3'b010,
                             fields.rd_rs1, rvc_pkg::LOAD};
                end
            end
            // ========================================
            // Register move and jump group
            // ========================================
            3'b100: begin
                if (!fields.bit12) begin
                    if (rs2_zero) begin
                        // JR
                        if (!rd_zero) begin
                            instr = {12'd0, fields.rd_rs1, 3'b000, `RVC_REG_ZERO, rvc_pkg::JALR};
                        end
                    end else if (!rd_zero) begin
                        // MV as add rd, x0, rs2
                        instr = {7'b000_0000, fields.rs2, `RVC_REG_ZERO, 3'b000,
                                 fields.rd_rs1, rvc_pkg::OP};
                    end
                end else if (rs2_zero) begin
                    // Both register fields zero is EBREAK
                    if (rd_zero) begin
                        instr = `RVC_EBREAK_WORD;
                    end else begin
                        instr = {12'd0, fields.rd_rs1, 3'b000, `RVC_REG_RA, rvc_pkg::JALR};
                    end
                end else if (!rd_zero) begin
                    // ADD
                    instr = {7'b000_0000, fields.rs2, fields.rd_rs1, 3'b000,
                             fields.rd_rs1, rvc_pkg::OP};
                end
            end
            // sw rs2, off(sp)
            3'b110: begin
                instr = {4'b0000, fields.swsp_off[7:5], fields.rs2, `RVC_REG_SP, 3'b010,
                         fields.swsp_off[4:0], rvc_pkg::STORE};
            end
            default: instr = `RVC_NOP_WORD;
        endcase
    end

endmodule

// File: rvc_settings.svh
// Instruction widths, register numbers and fixed RV32I words
// for the RVC decompressor
`ifndef RVC_SETTINGS_SVH
`define RVC_SETTINGS_SVH

// Full instruction and parcel widths
`define RVC_XLEN        32
`define RVC_HALF_W      16

// Canonical NOP is addi x0, x0, 0
`define RVC_NOP_WORD    32'h0000_0013
`define RVC_EBREAK_WORD 32'h0010_0073

// Architectural register numbers used by implied operands
`define RVC_REG_ZERO    5'd0
`define RVC_REG_RA      5'd1
`define RVC_REG_SP      5'd2

// High bits that turn a 3-bit register field into x8..x15
`define RVC_PRIME_BASE  2'b01

`endif

// File: tb_rvc_decompressor.sv
// Testbench for the RV32C decompressor
// LFSR stimulus, reference model, compare tasks and watchdog
`timescale 1ns/1ps
`include "rvc_settings.svh"

module tb_rvc_decompressor;

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 5;
    localparam int N_PASS       = 500;
    localparam int N_SPAN       = 500;
    localparam int N_NEXT       = 200;
    localparam int N_RAND       = 3000;
    localparam int N_DIRECTED   = 13;
    localparam int N_TESTS      = N_PASS + N_SPAN + N_NEXT + N_RAND + N_DIRECTED + 1;
    // Two periods per vector leaves plenty of margin
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_TESTS) * PERIOD * 2;

    logic                 clk = 1'b0;
    logic                 reset;
    rvc_pkg::fetch_in_t   fetch;
    rvc_pkg::decomp_out_t result;

    logic [31:0] lfsr_state = 32'd69;
    int          error_count = 0;
    int          check_count = 0;

    rvc_decompressor uut (.fetch(fetch), .result(result));

    always #(PERIOD / 2) clk = ~clk;

    // Reset held for the first cycles
    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

    // ========================================
    // Random source and RV32I encoders
    // ========================================

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic rvc_pkg::rv_instr_t i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] f3, input logic [4:0] rd,
                                                  input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    // Stores are always word wide here
    function automatic rvc_pkg::rv_instr_t s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                                  input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvc_pkg::STORE};
    endfunction

    // Compressed branches compare against x0
    function automatic rvc_pkg::rv_instr_t b_type(input logic [31:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] f3);
        return {imm[12], imm[10:5], `RVC_REG_ZERO, rs1, f3, imm[4:1], imm[11], rvc_pkg::BRANCH};
    endfunction

    function automatic rvc_pkg::rv_instr_t j_type(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvc_pkg::JAL};
    endfunction

    function automatic rvc_pkg::rv_instr_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3,
                                                  input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvc_pkg::OP};
    endfunction

    // ========================================
    // Reference model
    // ========================================

    // Expansion straight from the RVC tables
    function automatic rvc_pkg::rv_instr_t expand_model(input rvc_pkg::rvc_half_t h);
        logic [4:0]         rd;
        logic [4:0]         rs2;
        logic [4:0]         rdp;
        logic [4:0]         rs1p;
        logic [2:0]         alu_f3;
        logic               sh_bad;
        logic [31:0]        ci;
        logic [31:0]        sh;
        logic [31:0]        uimm;
        logic [31:0]        loff;
        logic [31:0]        jimm;
        logic [31:0]        bimm;
        logic [31:0]        spimm;
        rvc_pkg::rv_instr_t w;
        rd     = h[11:7];
        rs2    = h[6:2];
        rdp    = {2'b01, h[4:2]};
        rs1p   = {2'b01, h[9:7]};
        ci     = {{26{h[12]}}, h[12], h[6:2]};
        sh     = {27'd0, h[6:2]};
        sh_bad = h[12] || (h[6:2] == 5'd0);
        uimm   = '0;
        // CL/CS word offset
        loff    = '0;
        loff[5:3] = h[12:10];
        loff[2]   = h[6];
        loff[6]   = h[5];
        // CJ offset, sign from bit 12
        jimm       = {{21{h[12]}}, 11'd0};
        jimm[4]    = h[11];
        jimm[9:8]  = h[10:9];
        jimm[10]   = h[8];
        jimm[6]    = h[7];
        jimm[7]    = h[6];
        jimm[3:1]  = h[5:3];
        jimm[5]    = h[2];
        // CB offset
        bimm       = {{24{h[12]}}, 8'd0};
        bimm[4:3]  = h[11:10];
        bimm[7:6]  = h[6:5];
        bimm[2:1]  = h[4:3];
        bimm[5]    = h[2];
        // Stack adjust, multiple of 16
        spimm      = {{23{h[12]}}, 9'd0};
        spimm[4]   = h[6];
        spimm[6]   = h[5];
        spimm[8:7] = h[4:3];
        spimm[5]   = h[2];
        case (h[6:5])
            2'b00:   alu_f3 = 3'b000;
            2'b01:   alu_f3 = 3'b100;
            2'b10:   alu_f3 = 3'b110;
            default: alu_f3 = 3'b111;
        endcase
        w = `RVC_NOP_WORD;
        case (h[1:0])
            2'b00: begin
                case (h[15:13])
                    3'b000: begin
                        uimm[5:4] = h[12:11];
                        uimm[9:6] = h[10:7];
                        uimm[2]   = h[6];
                        uimm[3]   = h[5];
                        if (uimm != 32'd0)
                            w = i_type(uimm, `RVC_REG_SP, 3'b000, rdp, rvc_pkg::OP_IMM);
                    end
                    3'b010:  w = i_type(loff, rs1p, 3'b010, rdp, rvc_pkg::LOAD);
                    3'b110:  w = s_type(loff, rdp, rs1p);
                    default: w = `RVC_NOP_WORD;
                endcase
            end
            2'b01: begin
                case (h[15:13])
                    3'b000: if (rd != 5'd0) w = i_type(ci, rd, 3'b000, rd, rvc_pkg::OP_IMM);
                    3'b001: w = j_type(jimm, `RVC_REG_RA);
                    3'b010: if (rd != 5'd0) w = i_type(ci, 5'd0, 3'b000, rd, rvc_pkg::OP_IMM);
                    3'b011: begin
                        if (rd == `RVC_REG_SP) begin
                            if (spimm != 32'd0)
                                w = i_type(spimm, `RVC_REG_SP, 3'b000, `RVC_REG_SP,
                                           rvc_pkg::OP_IMM);
                        end else if (rd != 5'd0 && ci != 32'd0) begin
                            // LUI upper field is the sign-extended CI value
                            w = {ci[19:0], rd, rvc_pkg::LUI};
                        end
                    end
                    3'b100: begin
                        case (h[11:10])
                            2'b00: if (!sh_bad) w = i_type(sh, rs1p, 3'b101, rs1p, rvc_pkg::OP_IMM);
                            // SRAI, imm bit 10 is funct7 bit 5
                            2'b01: if (!sh_bad) w = i_type(sh | 32'h400, rs1p, 3'b101, rs1p,
                                                           rvc_pkg::OP_IMM);
                            2'b10: w = i_type(ci, rs1p, 3'b111, rs1p, rvc_pkg::OP_IMM);
                            default: begin
                                if (!h[12])
                                    w = r_type((h[6:5] == 2'b00) ? 7'h20 : 7'h00, rdp, rs1p,
                                               alu_f3, rs1p);
                            end
                        endcase
                    end
                    3'b101:  w = j_type(jimm, `RVC_REG_ZERO);
                    3'b110:  w = b_type(bimm, rs1p, 3'b000);
                    default: w = b_type(bimm, rs1p, 3'b001);
                endcase
            end
            2'b10: begin
                case (h[15:13])
                    3'b000: begin
                        if (rd != 5'd0 && !sh_bad)
                            w = i_type(sh, rd, 3'b001, rd, rvc_pkg::OP_IMM);
                    end
                    3'b010: begin
                        uimm[5]   = h[12];
                        uimm[4:2] = h[6:4];
                        uimm[7:6] = h[3:2];
                        if (rd != 5'd0)
                            w = i_type(uimm, `RVC_REG_SP, 3'b010, rd, rvc_pkg::LOAD);
                    end
                    3'b100: begin
                        if (rs2 != 5'd0) begin
                            // MV adds to x0, ADD adds to rd
                            if (rd != 5'd0)
                                w = r_type(7'h00, rs2, h[12] ? rd : 5'd0, 3'b000, rd);
                        end else if (rd != 5'd0) begin
                            // JR links nothing, JALR links ra
                            w = i_type(32'd0, rd, 3'b000, h[12] ? `RVC_REG_RA : `RVC_REG_ZERO,
                                       rvc_pkg::JALR);
                        end else if (h[12]) begin
                            w = `RVC_EBREAK_WORD;
                        end
                    end
                    3'b110: begin
                        uimm[5:2] = h[12:9];
                        uimm[7:6] = h[8:7];
                        w = s_type(uimm, rs2, `RVC_REG_SP);
                    end
                    default: w = `RVC_NOP_WORD;
                endcase
            end
            default: w = `RVC_NOP_WORD;
        endcase
        return w;
    endfunction

    // Selection order: spanning, compressed, waiting, pass-through
    function automatic rvc_pkg::decomp_out_t decomp_model(input rvc_pkg::fetch_in_t f);
        rvc_pkg::rvc_half_t   h;
        rvc_pkg::decomp_out_t d;
        h = f.pc_bit1 ? f.fetched_word[31:16] : f.fetched_word[15:0];
        d.is_compressed  = 1'b0;
        d.need_next_half = 1'b0;
        if (f.have_saved) begin
            d.instruction = {f.fetched_word[15:0], f.saved_half};
        end else if (h[1:0] != 2'b11) begin
            d.instruction   = expand_model(h);
            d.is_compressed = 1'b1;
        end else if (f.pc_bit1) begin
            d.instruction    = `RVC_NOP_WORD;
            d.need_next_half = 1'b1;
        end else begin
            d.instruction = f.fetched_word;
        end
        return d;
    endfunction

    // ========================================
    // Compare and drive tasks
    // ========================================

    task automatic check_instr(input rvc_pkg::rv_instr_t got, input rvc_pkg::rv_instr_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("error instruction got %h expected %h", got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string name);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("error %s got %h expected %h", name, got, want);
        end
    endtask

    // Drive on the rising edge, sample at the falling edge
    task automatic apply_vector(input rvc_pkg::fetch_in_t f);
        rvc_pkg::decomp_out_t want;
        @(posedge clk);
        fetch <= f;
        @(negedge clk);
        want = decomp_model(f);
        check_instr(result.instruction, want.instruction);
        check_flag(result.is_compressed, want.is_compressed, "is_compressed");
        check_flag(result.need_next_half, want.need_next_half, "need_next_half");
    endtask

    // Lower parcel only, expected word given directly
    task automatic check_reserved(input rvc_pkg::rvc_half_t h, input rvc_pkg::rv_instr_t want);
        rvc_pkg::fetch_in_t f;
        f = '0;
        f.fetched_word[15:0] = h;
        @(posedge clk);
        fetch <= f;
        @(negedge clk);
        check_instr(result.instruction, want);
        check_flag(result.is_compressed, 1'b1, "is_compressed");
        check_flag(result.need_next_half, 1'b0, "need_next_half");
    endtask

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        rvc_pkg::fetch_in_t f;
        logic [31:0]        r;
        logic               pc;
        logic [1:0]         quad;
        fetch <= '0;
        // Zero input under reset is the zero parcel, every reset cycle
        @(negedge clk);
        while (reset) begin
            check_instr(result.instruction, `RVC_NOP_WORD);
            check_flag(result.is_compressed, 1'b1, "is_compressed");
            check_flag(result.need_next_half, 1'b0, "need_next_half");
            @(negedge clk);
        end

        // Aligned 32-bit pass-through
        for (int i = 0; i < N_PASS; i++) begin
            r = random_bits(32);
            f = '0;
            f.fetched_word = {r[31:2], 2'b11};
            r = random_bits(16);
            f.saved_half = r[15:0];
            apply_vector(f);
        end

        // Spanning words, pc_bit1 random
        for (int i = 0; i < N_SPAN; i++) begin
            r = random_bits(32);
            f.fetched_word = r;
            r = random_bits(17);
            f.saved_half = r[15:0];
            f.pc_bit1    = r[16];
            f.have_saved = 1'b1;
            apply_vector(f);
        end

        // Upper half opens a 32-bit instruction
        for (int i = 0; i < N_NEXT; i++) begin
            r = random_bits(32);
            f = '0;
            f.fetched_word = {r[31:18], 2'b11, r[15:0]};
            f.pc_bit1      = 1'b1;
            apply_vector(f);
        end

        // Compressed parcels, quadrant cycles 0..2
        for (int i = 0; i < N_RAND; i++) begin
            r = random_bits(1);
            pc = r[0];
            quad = 2'(i % 3);
            r = random_bits(32);
            f = '0;
            f.pc_bit1 = pc;
            if (pc)
                f.fetched_word = {r[31:18], quad, r[15:0]};
            else
                f.fetched_word = {r[31:2], quad};
            apply_vector(f);
        end

        // Reserved, HINT and FP slots
        check_reserved(16'h0000, `RVC_NOP_WORD);
        check_reserved(16'h6101, `RVC_NOP_WORD);
        check_reserved(16'h6081, `RVC_NOP_WORD);
        check_reserved(16'h9005, `RVC_NOP_WORD);
        check_reserved(16'h0006, `RVC_NOP_WORD);
        check_reserved(16'h4002, `RVC_NOP_WORD);
        check_reserved(16'h8002, `RVC_NOP_WORD);
        check_reserved(16'h9C01, `RVC_NOP_WORD);
        check_reserved(16'h2444, `RVC_NOP_WORD);
        check_reserved(16'hA444, `RVC_NOP_WORD);
        check_reserved(16'h2086, `RVC_NOP_WORD);
        check_reserved(16'hA086, `RVC_NOP_WORD);
        check_reserved(16'h9002, `RVC_EBREAK_WORD);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule
